// File: dv/tm_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Concurrent checks on the grant, the queues and the Wishbone ack of tm_top.
module tm_assert import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [num_ports-1:0] sel_port,
	input wire logic [num_ports-1:0] pop,
	input wire logic [num_ports-1:0] nonempty,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic out_valid
);

	int unsigned fail_count = 0; // Read by the testbench every cycle and at the end.

	// The scheduler names at most one port per clock.
	a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(sel_port))
		else begin
			fail_count++;
			$error("grant is neither one-hot nor zero");
		end

	// An empty queue is never popped.
	a_pop_nonempty: assert property (@(posedge clk) disable iff (reset) (pop & ~nonempty) == '0)
		else begin
			fail_count++;
			$error("pop asserted on an empty queue");
		end

	a_ack_with_stb: assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_stb)
		else begin
			fail_count++;
			$error("ack seen without stb");
		end

	a_ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("ack held for two cycles");
		end

	// A zero grant pops nothing, so the next cycle has no output.
	a_no_grant_no_out: assert property (@(posedge clk) disable iff (reset)
		(sel_port == '0) |=> !out_valid)
		else begin
			fail_count++;
			$error("output valid after a cycle without grant");
		end

endmodule

bind tm_top tm_assert i_assert (
	.clk(clk), .reset(reset), .sel_port(sel_port), .pop(pop), .nonempty(nonempty),
	.wb_stb(wb_stb), .wb_ack(wb_ack), .out_valid(out_valid)
);

`default_nettype wire

// File: dv/tm_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free running 100 ns clock and a synchronous reset for the testbench.
module tm_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // Half of the 100 ns period.
	end

	// Reset covers three rising edges and drops on a falling edge.
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/tm_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the traffic manager output stage.
// A model of the eight queues and the TDM slot order predicts every output.
module tm_tb import tm_pkg::*; ();

	localparam int max_cycles = 20000; // Roughly four times the full run.
	localparam int push_rounds = 1500; // Random pushes with the scheduler running.
	localparam int mode_idle = 0; // No output may appear.
	localparam int mode_drain = 1; // Outputs follow the slot order.
	localparam int mode_free = 2; // Only per-port FIFO order is checked.

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [wb_adr_w-1:0] wb_adr;
	logic [wb_data_w-1:0] wb_dat_w;
	logic [wb_data_w-1:0] wb_dat_r;
	logic wb_ack;
	logic out_valid;
	logic [port_id_w-1:0] out_port;
	logic [desc_w-1:0] out_desc;

	logic [31:0] seed;
	logic [desc_w-1:0] model_q [num_ports][$]; // Descriptors the DUT still holds.
	int sent_model [num_ports]; // Outputs seen per port.
	int mode;
	int gen_slot; // Slot order generator, starting at slot zero.
	int gen_fast;
	int gen_slow;
	int slow_order [5] = '{5, 6, 7, 5, 6}; // Slow slot owners over five frames.
	int exp_port;
	int cycle_cnt = 0;
	logic [wb_data_w-1:0] rd_val;
	logic [port_id_w-1:0] rnd_port;

	tm_clock_gen i_clk_gen (.clk(clk), .reset(reset));

	tm_top i_dut (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.out_valid(out_valid), .out_port(out_port), .out_desc(out_desc)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_and_stop();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(input string why);
		$display("error at %0t: %s", $time, why);
		fail_and_stop();
	endtask

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
			fail_and_stop();
		end
	endtask

	// Starts on a falling edge. Holds the request through the ack edge and
	// returns on the falling edge after it with the bus idle.
	task automatic bus_cycle(input logic we, input logic [wb_adr_w-1:0] adr,
			input logic [wb_data_w-1:0] wdata, output logic [wb_data_w-1:0] rdata);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		rdata = wb_dat_r; // Read data is stable through the ack cycle.
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic read_expect(input logic [wb_adr_w-1:0] adr,
			input logic [wb_data_w-1:0] exp, input string what);
		logic [wb_data_w-1:0] data;
		bus_cycle(1'b0, adr, '0, data);
		compare(data, exp, what);
	endtask

	task automatic check_sent(input string what);
		for (int p = 0; p < num_ports; p++) begin
			read_expect(wb_adr_w'(8 + p), sent_model[p], what);
		end
	endtask

	// Full flags in the low byte and nonempty flags in the next byte.
	function automatic logic [31:0] expected_status();
		logic [31:0] s;
		s = '0;
		for (int p = 0; p < num_ports; p++) begin
			s[p] = (model_q[p].size() == queue_depth);
			s[8 + p] = (model_q[p].size() != 0);
		end
		return s;
	endfunction

	// Descriptors still expected on the output. Port 4 has no slot.
	function automatic int pending();
		int n;
		n = 0;
		for (int p = 0; p < num_ports; p++) begin
			if (p != 4) n += model_q[p].size();
		end
		return n;
	endfunction

	task automatic wait_drained();
		while (pending() != 0) @(negedge clk);
	endtask

	// Sixteen fast slots over ports 0 to 3, then one slow slot.
	task automatic next_slot_port(output int port);
		if (gen_slot == slot_last) begin
			port = slow_order[gen_slow];
			gen_slow = (gen_slow == slow_last) ? 0 : gen_slow + 1;
			gen_slot = 0;
		end else begin
			port = gen_fast;
			gen_fast = (gen_fast == fast_last) ? 0 : gen_fast + 1;
			gen_slot++;
		end
	endtask

	// Empty ports waste their slot, so skip ahead to the next busy one.
	task automatic expect_drain_port(output int port);
		int guard;
		guard = 0;
		next_slot_port(port);
		while (model_q[port].size() == 0) begin
			guard++;
			if (guard > 100) abort_run("output seen but no queued port is left in the slot order");
			else next_slot_port(port);
		end
	endtask

	// Output monitor, sampled on the falling edge.
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			if (mode == mode_idle) begin
				abort_run("an output appeared while none was expected");
			end else begin
				if (mode == mode_drain) begin
					expect_drain_port(exp_port);
					compare(out_port, exp_port, "port in drain order");
				end
				if (model_q[out_port].size() == 0) begin
					abort_run("an output came from a port with nothing queued");
				end else begin
					compare(out_desc, model_q[out_port][0], "output descriptor");
					void'(model_q[out_port].pop_front());
					sent_model[out_port]++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == max_cycles) abort_run("timeout, the run did not reach its end");
		else if (i_dut.i_assert.fail_count != 0) abort_run("a concurrent assertion failed");
	end

	initial begin
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		seed = 32'h4a55_2571;
		mode = mode_idle;
		gen_slot = 0;
		gen_fast = 0;
		gen_slow = 0;
		foreach (sent_model[p]) sent_model[p] = 0;
		@(negedge clk);
		while (reset) @(negedge clk);

		compare(out_valid, 1'b0, "out_valid after reset");
		read_expect(reg_status, '0, "status after reset");
		check_sent("sent counter after reset");

		// Fill with the scheduler stopped. Pushes past eight are dropped by the DUT.
		for (int i = 0; i < 60; i++) begin
			seed = xorshift(seed);
			rnd_port = seed[18:16];
			bus_cycle(1'b1, reg_enq, {13'd0, rnd_port, seed[15:0]}, rd_val);
			if (model_q[rnd_port].size() < queue_depth) model_q[rnd_port].push_back(seed[15:0]);
		end
		read_expect(reg_status, expected_status(), "status after fill");
		repeat (20) @(negedge clk);

		mode = mode_drain;
		bus_cycle(1'b1, reg_ctrl, 32'd1, rd_val);
		wait_drained();
		check_sent("sent counter after drain");
		read_expect(reg_status, expected_status(), "status after drain"); // Port 4 still filled.

		// Random traffic while running. A port is kept below eight entries.
		// A running scheduler can send a descriptor out before its bus cycle returns.
		mode = mode_free;
		for (int i = 0; i < push_rounds; i++) begin
			seed = xorshift(seed);
			rnd_port = seed[18:16];
			if (rnd_port == 3'd4) rnd_port = {1'b0, seed[20:19]};
			if (model_q[rnd_port].size() < queue_depth - 1) begin
				model_q[rnd_port].push_back(seed[15:0]);
				bus_cycle(1'b1, reg_enq, {13'd0, rnd_port, seed[15:0]}, rd_val);
			end else begin
				@(negedge clk);
			end
		end
		wait_drained();
		check_sent("sent counter after traffic");

		// Load the slow port 7 and then pause the scheduler.
		for (int i = 0; i < 4; i++) begin
			seed = xorshift(seed);
			model_q[7].push_back(seed[15:0]);
			bus_cycle(1'b1, reg_enq, {13'd0, 3'd7, seed[15:0]}, rd_val);
		end
		bus_cycle(1'b1, reg_ctrl, 32'd0, rd_val);
		// The cycle right after the ack cycle may still carry a last output.
		// Port 7 owns a slot once in 85, so a running scheduler would hit it here.
		repeat (100) begin
			@(negedge clk);
			compare(out_valid, 1'b0, "out_valid while paused");
		end
		read_expect(reg_ctrl, 32'd0, "enable after pause");
		read_expect(reg_status, expected_status(), "status while paused");

		if (i_dut.i_assert.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("%0d assertion failures were reported", i_dut.i_assert.fail_count);
			fail_and_stop();
		end
	end

endmodule

`default_nettype wire

// File: rtl/tm_dequeue.sv
`timescale 1ns/1ps
`default_nettype none

// Dequeue stage.
// The scheduler grant is masked with queue occupancy to form the pop.
// The popped head descriptor and its port id appear on the output one clock later.
// A grant to an empty queue simply wastes the slot.
module tm_dequeue import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [num_ports-1:0] sel_port,
	input wire logic [port_id_w-1:0] sel_port_id,
	input wire logic [num_ports-1:0] nonempty,
	input wire logic [num_ports-1:0][desc_w-1:0] head_desc,
	output logic [num_ports-1:0] pop,
	output logic out_valid,
	output logic [port_id_w-1:0] out_port,
	output logic [desc_w-1:0] out_desc,
	output logic [num_ports-1:0][count_w-1:0] sent_count
);

	logic any_pop; // Some queue gives up its head this cycle.

	// Pop is combinational so the FIFO advances on the same edge the output loads.
	assign pop = sel_port & nonempty;
	assign any_pop = |pop;

	// The valid flag is control state and is cleared by reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= any_pop;
		end
	end

	// Port id and descriptor only load on a real pop.
	always_ff @(posedge clk) begin
		if (any_pop) begin
			out_port <= sel_port_id;
			out_desc <= head_desc[sel_port_id]; // Old head, before the pointer moves.
		end
	end

	// One sent counter per port, bumped on every pop of that port.
	// The counters wrap silently at 2^count_w.
	always_ff @(posedge clk) begin
		if (reset) begin
			sent_count <= '0;
		end else begin
			for (int i = 0; i < num_ports; i++) begin
				if (pop[i]) begin
					sent_count[i] <= sent_count[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/tm_pkg.sv
`default_nettype none

// Shared constants and the register map of the traffic manager output stage.
package tm_pkg;

	// Port geometry.
	localparam int num_ports = 8; // Output ports 0 to 7.
	localparam int port_id_w = 3; // Enough bits to name any port.

	// Descriptor and queue sizing.
	localparam int desc_w = 16; // Only descriptors move, no payload.
	localparam int queue_depth = 8; // Entries in each per-port FIFO.
	localparam int queue_ptr_w = 3; // Read and write pointers wrap on their own.
	localparam int queue_cnt_w = queue_ptr_w + 1; // Occupancy must also hold the value 8.

	// Width of each per-port sent counter; the counters wrap.
	localparam int count_w = 16;

	// TDM frame layout.
	// A frame is slots 0 to slot_last, and the final slot belongs to a slow port.
	localparam int slot_last = 16;
	localparam int fast_last = 3; // Fast rotation covers ports 0 to 3.
	localparam int slow_last = 4; // Five slow entries per cycle of frames.
	localparam int slow_base = 5; // First slow port id.
	localparam int slow_ports = 3; // Ports 5, 6 and 7.

	// Counter widths derived from the limits above.
	localparam int slot_w = $clog2(slot_last + 1);
	localparam int fast_w = $clog2(fast_last + 1);
	localparam int slow_w = $clog2(slow_last + 1);

	// Wishbone bus widths.
	localparam int wb_adr_w = 4; // Word addresses 0 to 15.
	localparam int wb_data_w = 32;

	// Register word addresses.
	// The sent counters occupy 8 to 15, so reg_sent stands for the whole upper half.
	typedef enum logic [wb_adr_w-1:0] {
		reg_ctrl = 4'd0, // Bit 0 is the scheduler enable.
		reg_enq = 4'd1, // Write only; bits 18..16 port, bits 15..0 descriptor.
		reg_status = 4'd2, // Full flags low byte, nonempty flags next byte.
		reg_sent = 4'd8 // Sent counter of port (address - 8).
	} wb_reg_e;

endpackage

`default_nettype wire

// File: rtl/tm_port_queues.sv
`timescale 1ns/1ps
`default_nettype none

// Eight descriptor FIFOs, one per output port.
// The host side pushes by port id, and the dequeue side pops by a one-hot vector.
// Each FIFO is a small circular buffer with its own pointers and occupancy.
module tm_port_queues import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire logic [port_id_w-1:0] push_port,
	input wire logic [desc_w-1:0] push_desc,
	input wire logic [num_ports-1:0] pop,
	output logic [num_ports-1:0][desc_w-1:0] head_desc,
	output logic [num_ports-1:0] nonempty,
	output logic [num_ports-1:0] full
);

	logic [desc_w-1:0] mem [num_ports][queue_depth]; // Descriptor storage.
	logic [queue_ptr_w-1:0] rd_ptr [num_ports]; // Head entry of each FIFO.
	logic [queue_ptr_w-1:0] wr_ptr [num_ports]; // Next free entry.
	logic [queue_cnt_w-1:0] count [num_ports]; // Entries held, 0 to 8.

	logic [num_ports-1:0] push_hit; // Push request decoded to a port.
	logic [num_ports-1:0] do_push;
	logic [num_ports-1:0] do_pop;

	assign push_hit = push ? (num_ports'(1) << push_port) : '0;

	// A pop of an empty FIFO is meaningless and is ignored.
	assign do_pop = pop & nonempty;

	// A push to a full FIFO is dropped.
	// When the same FIFO pops in that cycle a slot frees up, so both go through.
	assign do_push = push_hit & (~full | do_pop);

	for (genvar p = 0; p < num_ports; p++) begin : g_port

		assign nonempty[p] = (count[p] != '0);
		assign full[p] = (count[p] == queue_cnt_w'(queue_depth));

		// The head is read straight out of the buffer, no output register.
		assign head_desc[p] = mem[p][rd_ptr[p]];

		// Storage itself needs no reset; the pointers say what is valid.
		always_ff @(posedge clk) begin
			if (do_push[p]) begin
				mem[p][wr_ptr[p]] <= push_desc;
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				rd_ptr[p] <= '0;
				wr_ptr[p] <= '0;
				count[p] <= '0;
			end else begin
				// Pointers are exactly as wide as the depth, so they wrap by themselves.
				if (do_push[p]) begin
					wr_ptr[p] <= wr_ptr[p] + 1'b1;
				end
				if (do_pop[p]) begin
					rd_ptr[p] <= rd_ptr[p] + 1'b1;
				end
				case ({do_push[p], do_pop[p]})
					2'b10: count[p] <= count[p] + 1'b1;
					2'b01: count[p] <= count[p] - 1'b1;
					default: count[p] <= count[p]; // Both or neither leaves it unchanged.
				endcase
			end
		end

	end

endmodule

`default_nettype wire

// File: rtl/tm_port_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

// Fixed TDM port scheduler.
// Each frame has 17 slots. Slots 0 to 15 rotate over the fast ports 0 to 3,
// and slot 16 is given to a slow port. Slow ports rotate 5, 6, 7, 5, 6
// across five frames. Port 4 is never granted in this configuration.
module tm_port_scheduler import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic en,
	output logic [num_ports-1:0] sel_port,
	output logic [port_id_w-1:0] sel_port_id
);

	logic [slot_w-1:0] slot_cnt; // Position inside the current frame.
	logic [fast_w-1:0] fast_cnt; // Next fast port to serve.
	logic [slow_w-1:0] slow_cnt; // Index into the five-entry slow rotation.

	logic last_slot; // The slow slot closes the frame.
	logic [port_id_w-1:0] slow_id;
	logic [port_id_w-1:0] next_id;

	assign last_slot = (slot_cnt == slot_w'(slot_last));

	// Entries 0, 1, 2 map to ports 5, 6, 7 and entries 3, 4 wrap back to 5, 6.
	always_comb begin
		if (slow_cnt < slow_w'(slow_ports)) begin
			slow_id = port_id_w'(slow_base) + port_id_w'(slow_cnt);
		end else begin
			slow_id = port_id_w'(slow_base) + port_id_w'(slow_cnt - slow_w'(slow_ports));
		end
	end

	// Port id owning the slot the counters point at right now.
	assign next_id = last_slot ? slow_id : port_id_w'(fast_cnt);

	// Slot counters only move while enabled, so a pause resumes where it stopped.
	always_ff @(posedge clk) begin
		if (reset) begin
			slot_cnt <= '0;
			fast_cnt <= '0;
			slow_cnt <= '0;
		end else if (en) begin
			slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
			if (last_slot) begin
				// Only the slow slot advances the slow rotation.
				slow_cnt <= (slow_cnt == slow_w'(slow_last)) ? '0 : slow_cnt + 1'b1;
			end else begin
				fast_cnt <= (fast_cnt == fast_w'(fast_last)) ? '0 : fast_cnt + 1'b1;
			end
		end
	end

	// The grant is registered, one cycle behind the counters.
	// With the enable low both outputs drop to zero and nothing is granted.
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_port <= '0;
			sel_port_id <= '0;
		end else if (en) begin
			sel_port <= num_ports'(1) << next_id; // One-hot form of the same slot.
			sel_port_id <= next_id;
		end else begin
			sel_port <= '0;
			sel_port_id <= '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/tm_top.sv
`timescale 1ns/1ps
`default_nettype none

// Output stage of the traffic manager.
// Host enqueues through Wishbone, and the TDM scheduler drains the per-port queues.
module tm_top import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [wb_adr_w-1:0] wb_adr,
	input wire logic [wb_data_w-1:0] wb_dat_w,
	output logic [wb_data_w-1:0] wb_dat_r,
	output logic wb_ack,
	output logic out_valid,
	output logic [port_id_w-1:0] out_port,
	output logic [desc_w-1:0] out_desc
);

	logic sched_en; // Control register bit 0.
	logic push;
	logic [port_id_w-1:0] push_port;
	logic [desc_w-1:0] push_desc;
	logic [num_ports-1:0] pop;
	logic [num_ports-1:0] nonempty;
	logic [num_ports-1:0] full;
	logic [num_ports-1:0][desc_w-1:0] head_desc; // Head of every queue at once.
	logic [num_ports-1:0] sel_port; // One-hot grant.
	logic [port_id_w-1:0] sel_port_id;
	logic [num_ports-1:0][count_w-1:0] sent_count;

	tm_wb_regs i_wb_regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.full(full), .nonempty(nonempty), .sent_count(sent_count),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .sched_en(sched_en),
		.push(push), .push_port(push_port), .push_desc(push_desc)
	);

	tm_port_queues i_queues (
		.clk(clk), .reset(reset),
		.push(push), .push_port(push_port), .push_desc(push_desc), .pop(pop),
		.head_desc(head_desc), .nonempty(nonempty), .full(full)
	);

	tm_port_scheduler i_scheduler (
		.clk(clk), .reset(reset), .en(sched_en),
		.sel_port(sel_port), .sel_port_id(sel_port_id)
	);

	// Pop feeds back into the queues in the same cycle.
	tm_dequeue i_dequeue (
		.clk(clk), .reset(reset),
		.sel_port(sel_port), .sel_port_id(sel_port_id),
		.nonempty(nonempty), .head_desc(head_desc),
		.pop(pop), .out_valid(out_valid), .out_port(out_port), .out_desc(out_desc),
		.sent_count(sent_count)
	);

endmodule

`default_nettype wire

// File: rtl/tm_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave holding the host-visible registers.
// Every access gets a single-cycle ack, one clock after cyc and stb are seen.
// Writes, enqueue pushes and read data are all taken on the edge that raises ack.
module tm_wb_regs import tm_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [wb_adr_w-1:0] wb_adr,
	input wire logic [wb_data_w-1:0] wb_dat_w,
	input wire logic [num_ports-1:0] full,
	input wire logic [num_ports-1:0] nonempty,
	input wire logic [num_ports-1:0][count_w-1:0] sent_count,
	output logic [wb_data_w-1:0] wb_dat_r,
	output logic wb_ack,
	output logic sched_en,
	output logic push,
	output logic [port_id_w-1:0] push_port,
	output logic [desc_w-1:0] push_desc
);

	logic req; // A new access that has not been acked yet.
	logic wr_req;
	logic rd_req;
	wb_reg_e reg_sel; // Decoded register.
	logic [wb_data_w-1:0] rd_data;

	// While ack is high the same access is still on the bus, so it is not new.
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign wr_req = req & wb_we;
	assign rd_req = req & ~wb_we;

	// The whole upper half of the map is the sent counter window.
	// Unused lower addresses fall through to the default arms below.
	assign reg_sel = wb_adr[wb_adr_w-1] ? reg_sent : wb_reg_e'(wb_adr);

	// Enqueue fields come straight off the write data.
	assign push = wr_req & (reg_sel == reg_enq);
	assign push_port = wb_dat_w[desc_w +: port_id_w]; // Bits 18..16.
	assign push_desc = wb_dat_w[desc_w-1:0]; // Bits 15..0.

	// Read multiplexer.
	always_comb begin
		case (reg_sel)
			reg_ctrl: rd_data = wb_data_w'(sched_en);
			reg_status: rd_data = wb_data_w'({nonempty, full});
			reg_sent: rd_data = wb_data_w'(sent_count[wb_adr[port_id_w-1:0]]);
			default: rd_data = '0; // The enqueue register is write only, others unmapped.
		endcase
	end

	// Ack and the control register.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			sched_en <= 1'b0; // The scheduler comes up stopped.
		end else begin
			wb_ack <= req; // High for exactly one cycle per access.
			if (wr_req && (reg_sel == reg_ctrl)) begin
				sched_en <= wb_dat_w[0];
			end
		end
	end

	// Read data is sampled with the access so it is stable during ack.
	always_ff @(posedge clk) begin
		if (rd_req) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
rtl/tm_pkg.sv
rtl/tm_port_scheduler.sv
rtl/tm_port_queues.sv
rtl/tm_dequeue.sv
rtl/tm_wb_regs.sv
rtl/tm_top.sv
dv/tm_clock_gen.sv
dv/tm_assert.sv
dv/tm_tb.sv
